/* rename_macros.svh */
//##########################################################################
// Size definitions for the rename stage, included by the package and RTL
//##########################################################################

`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

`define RN_NUM_ARCH_REGS 32                     // Architectural registers x0 to x31
`define RN_NUM_PHYS_REGS 64                     // Physical registers p0 to p63
`define RN_ARCH_BITS     5                      // Index width of an architectural register
`define RN_PHYS_BITS     6                      // Index width of a physical register

// Registers not mapped after reset are the ones the free list starts with
`define RN_FREE_DEPTH    (`RN_NUM_PHYS_REGS - `RN_NUM_ARCH_REGS)

`endif

/* rename_pkg.sv */
//##########################################################################
// Register index types shared by all rename stage modules
//##########################################################################

`include "rename_macros.svh"

package rename_pkg;

    // Logical register index as it comes from decode
    typedef logic [`RN_ARCH_BITS-1:0] arch_reg_t;

    // Physical register index into the 64 entry register file
    typedef logic [`RN_PHYS_BITS-1:0] phys_reg_t;

endpackage

/* rat_if.sv */
//##########################################################################
// Lookup and update bus between the alias table and the rename control
//##########################################################################

interface rat_if;

    rename_pkg::arch_reg_t src1_idx;            // Lookup index of source 1
    rename_pkg::arch_reg_t src2_idx;            // Lookup index of source 2
    rename_pkg::arch_reg_t dst_idx;             // Lookup index of the destination

    rename_pkg::phys_reg_t src1_map;            // Current mapping of source 1
    rename_pkg::phys_reg_t src2_map;            // Current mapping of source 2
    rename_pkg::phys_reg_t dst_map;             // Current mapping of the destination

    logic                  wr_en;               // Map update strobe
    rename_pkg::arch_reg_t wr_idx;              // Entry to update
    rename_pkg::phys_reg_t wr_map;              // New physical register for that entry

    // Table side answers lookups and takes the update
    modport tbl (
        input  src1_idx, src2_idx, dst_idx,
        output src1_map, src2_map, dst_map,
        input  wr_en, wr_idx, wr_map
    );

    // Control side drives lookups and the update
    modport ctrl (
        output src1_idx, src2_idx, dst_idx,
        input  src1_map, src2_map, dst_map,
        output wr_en, wr_idx, wr_map
    );

endinterface

/* register_alias_table.sv */
//##########################################################################
// Architectural to physical map with three lookups and one update per cycle
//##########################################################################

`include "rename_macros.svh"

module register_alias_table (
    input  logic  clk_i,                        // Core clock
    input  logic  rstn_i,                       // Async reset, active low
    rat_if.tbl    rat                           // Lookup and update bus
);

    localparam int NUM_ENTRIES = `RN_NUM_ARCH_REGS;

    // One physical register per architectural register
    rename_pkg::phys_reg_t map_q [NUM_ENTRIES];

    logic wr_allowed;                           // Update passes the x0 guard

    // x0 is pinned to p0 and its entry never changes
    assign wr_allowed = rat.wr_en && (rat.wr_idx != '0);

    // Map update
    // Reset returns every xN to pN and leaves p32 and up unused
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                map_q[i] <= rename_pkg::phys_reg_t'(i);  // Identity mapping
            end
        end else if (wr_allowed) begin
            map_q[rat.wr_idx] <= rat.wr_map;    // Visible to lookups after this edge
        end
    end

    // Combinational lookups of the current map
    // A request in the same cycle as an update still sees the old entry
    assign rat.src1_map = map_q[rat.src1_idx];  // Source 1 operand
    assign rat.src2_map = map_q[rat.src2_idx];  // Source 2 operand
    assign rat.dst_map  = map_q[rat.dst_idx];   // Previous destination freed at commit

endmodule

/* free_list.sv */
//##########################################################################
// Circular FIFO of unused physical registers, popped at rename, pushed at commit
//##########################################################################

`include "rename_macros.svh"

module free_list (
    input  logic                  clk_i,            // Core clock
    input  logic                  rstn_i,           // Async reset, active low
    input  logic                  pop_i,            // Take the head register
    input  logic                  commit_valid_i,   // Commit returns a register
    input  rename_pkg::phys_reg_t commit_prd_i,     // Register freed at commit
    output rename_pkg::phys_reg_t alloc_reg_o,      // Next register to allocate
    output logic                  empty_o           // No register left
);

    localparam int DEPTH    = `RN_FREE_DEPTH;
    localparam int FIRST_PR = `RN_NUM_ARCH_REGS;   // First register not mapped at reset
    localparam int PTR_W    = $clog2(DEPTH);
    localparam int CNT_W    = $clog2(DEPTH + 1);

    rename_pkg::phys_reg_t fifo_q [DEPTH];          // Free register storage

    logic [PTR_W-1:0] head_q;                       // Oldest free register
    logic [PTR_W-1:0] tail_q;                       // Slot for the next push
    logic [CNT_W-1:0] count_q;                      // Number of free registers
    logic [PTR_W-1:0] head_nxt;
    logic [PTR_W-1:0] tail_nxt;
    logic             push_en;

    // p0 belongs to x0 for good and must not re-enter the list
    assign push_en = commit_valid_i && (commit_prd_i != '0);

    // Pointer advance with wrap at the last slot
    assign head_nxt = (head_q == PTR_W'(DEPTH - 1)) ? '0 : head_q + 1'b1;
    assign tail_nxt = (tail_q == PTR_W'(DEPTH - 1)) ? '0 : tail_q + 1'b1;

    // Storage and pointers
    // Reset fills every slot so the list starts full with p32 first
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                fifo_q[i] <= rename_pkg::phys_reg_t'(FIRST_PR + i);
            end
            head_q <= '0;
            tail_q <= '0;                           // Full list, tail meets head
        end else begin
            if (push_en) begin
                fifo_q[tail_q] <= commit_prd_i;     // Poppable from the next cycle
                tail_q         <= tail_nxt;
            end
            if (pop_i) begin
                head_q <= head_nxt;                 // Control pops only when not empty
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            count_q <= CNT_W'(DEPTH);
        end else begin
            case ({push_en, pop_i})
                2'b10:   count_q <= count_q + 1'b1; // Commit only
                2'b01:   count_q <= count_q - 1'b1; // Allocation only
                default: count_q <= count_q;        // Both or neither
            endcase
        end
    end

    assign alloc_reg_o = fifo_q[head_q];            // Valid whenever not empty
    assign empty_o     = (count_q == '0);

endmodule

/* rename_control.sv */
//##########################################################################
// Rename decision logic, drives the map update and registers the result
//##########################################################################

module rename_control (
    input  logic                  clk_i,            // Core clock
    input  logic                  rstn_i,           // Async reset, active low
    input  logic                  req_valid_i,      // Single cycle rename request
    input  rename_pkg::arch_reg_t req_rs1_i,        // Source register 1
    input  rename_pkg::arch_reg_t req_rs2_i,        // Source register 2
    input  rename_pkg::arch_reg_t req_rd_i,         // Destination register
    input  logic                  req_rd_we_i,      // Instruction writes rd
    input  rename_pkg::phys_reg_t alloc_reg_i,      // Head of the free list
    input  logic                  free_empty_i,     // Free list exhausted
    rat_if.ctrl                   rat,              // Alias table bus
    output logic                  pop_o,            // Consume the free list head
    output logic                  res_valid_o,      // Rename result strobe
    output logic                  res_stall_o,      // Request dropped strobe
    output rename_pkg::phys_reg_t res_prs1_o,       // Physical source 1
    output rename_pkg::phys_reg_t res_prs2_o,       // Physical source 2
    output rename_pkg::phys_reg_t res_prd_o,        // Physical destination
    output rename_pkg::phys_reg_t res_old_prd_o     // Previous mapping of rd
);

    logic                  needs_alloc;             // Request wants a new register
    logic                  do_alloc;                // Allocation goes ahead
    logic                  do_stall;                // Allocation blocked by empty list
    rename_pkg::phys_reg_t prd_sel;                 // Destination to report

    logic                  valid_q;
    logic                  stall_q;
    rename_pkg::phys_reg_t prs1_q;
    rename_pkg::phys_reg_t prs2_q;
    rename_pkg::phys_reg_t prd_q;
    rename_pkg::phys_reg_t old_prd_q;

    // Lookups follow the request directly
    assign rat.src1_idx = req_rs1_i;
    assign rat.src2_idx = req_rs2_i;
    assign rat.dst_idx  = req_rd_i;

    // Writes to x0 are discarded, so they keep p0 and allocate nothing
    assign needs_alloc = req_valid_i && req_rd_we_i && (req_rd_i != '0);
    assign do_alloc    = needs_alloc && !free_empty_i;
    assign do_stall    = needs_alloc && free_empty_i;

    // Map update and free list pop happen together
    assign pop_o      = do_alloc;
    assign rat.wr_en  = do_alloc;
    assign rat.wr_idx = req_rd_i;
    assign rat.wr_map = alloc_reg_i;

    // Without allocation the destination stays on its current mapping
    assign prd_sel = do_alloc ? alloc_reg_i : rat.dst_map;

    // Result strobes
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
            stall_q <= 1'b0;
        end else begin
            valid_q <= req_valid_i && !do_stall;    // Dropped requests give no result
            stall_q <= do_stall;
        end
    end

    // Result payload, meaningful only with the valid strobe
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            prs1_q    <= rat.src1_map;              // Sources read the map before the update
            prs2_q    <= rat.src2_map;
            prd_q     <= prd_sel;
            old_prd_q <= rat.dst_map;               // Freed when this instruction commits
        end
    end

    assign res_valid_o   = valid_q;
    assign res_stall_o   = stall_q;
    assign res_prs1_o    = prs1_q;
    assign res_prs2_o    = prs2_q;
    assign res_prd_o     = prd_q;
    assign res_old_prd_o = old_prd_q;

endmodule

/* rename_top.sv */
//##########################################################################
// Register rename stage top level with one rename per cycle and 1 cycle latency
//##########################################################################

module rename_top (
    input  logic                  clk_i,            // Core clock
    input  logic                  rstn_i,           // Async reset, active low
    input  logic                  rename_valid_i,   // Rename request strobe
    input  rename_pkg::arch_reg_t rs1_i,            // Source register 1
    input  rename_pkg::arch_reg_t rs2_i,            // Source register 2
    input  rename_pkg::arch_reg_t rd_i,             // Destination register
    input  logic                  rd_we_i,          // Instruction writes rd
    input  logic                  commit_valid_i,   // Commit frees a register
    input  rename_pkg::phys_reg_t commit_prd_i,     // Register returned at commit
    output logic                  rename_valid_o,   // Result strobe
    output logic                  rename_stall_o,   // Request dropped for lack of a free register
    output rename_pkg::phys_reg_t prs1_o,           // Physical source 1
    output rename_pkg::phys_reg_t prs2_o,           // Physical source 2
    output rename_pkg::phys_reg_t prd_o,            // Physical destination
    output rename_pkg::phys_reg_t old_prd_o         // Mapping to free at commit
);

    rename_pkg::phys_reg_t alloc_reg;               // Free list head to control
    logic                  free_empty;              // Free list exhausted
    logic                  free_pop;                // Control consumes the head

    rat_if rat_bus ();                              // Table lookup and update bus

    register_alias_table register_alias_table_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .rat    (rat_bus.tbl)
    );

    free_list free_list_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .pop_i          (free_pop),
        .commit_valid_i (commit_valid_i),
        .commit_prd_i   (commit_prd_i),
        .alloc_reg_o    (alloc_reg),
        .empty_o        (free_empty)
    );

    rename_control rename_control_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .req_valid_i   (rename_valid_i),
        .req_rs1_i     (rs1_i),
        .req_rs2_i     (rs2_i),
        .req_rd_i      (rd_i),
        .req_rd_we_i   (rd_we_i),
        .alloc_reg_i   (alloc_reg),
        .free_empty_i  (free_empty),
        .rat           (rat_bus.ctrl),
        .pop_o         (free_pop),
        .res_valid_o   (rename_valid_o),
        .res_stall_o   (rename_stall_o),
        .res_prs1_o    (prs1_o),
        .res_prs2_o    (prs2_o),
        .res_prd_o     (prd_o),
        .res_old_prd_o (old_prd_o)
    );

endmodule

/* tb_clock_gen.sv */
//##########################################################################
// Testbench clock and active low reset source for the rename stage testbench
//##########################################################################

module tb_clock_gen #(
    parameter int PERIOD       = 40,            // Clock period in time units
    parameter int RESET_CYCLES = 3              // Rising edges with reset held low
) (
    output logic clk_o,                         // Free running clock
    output logic rstn_o                         // Async reset, active low
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;   // 50 percent duty cycle
    end

    initial begin
        rstn_o = 1'b0;                          // Held from time zero
        repeat (RESET_CYCLES) @(posedge clk_o);
        #5 rstn_o = 1'b1;                       // Released away from the edge
    end

endmodule

/* tb_rename_top.sv */
//##########################################################################
// Directed and random testbench of the rename stage against a reference model
//##########################################################################

`include "rename_macros.svh"

module tb_rename_top;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 3;
    localparam int DRIVE_DELAY     = 5;         // Inputs change this long after the edge
    localparam int SEED            = 29143;
    localparam int ALLOC_RUN       = 5;         // Writing renames in the order test
    localparam int DIRECTED_CYCLES = 50;        // Upper bound of the directed tests
    localparam int RANDOM_CYCLES   = 300;
    localparam int MARGIN_CYCLES   = 20;

    logic                  clk;
    logic                  rstn;
    logic                  rename_valid_i;
    rename_pkg::arch_reg_t rs1_i;
    rename_pkg::arch_reg_t rs2_i;
    rename_pkg::arch_reg_t rd_i;
    logic                  rd_we_i;
    logic                  commit_valid_i;
    rename_pkg::phys_reg_t commit_prd_i;
    logic                  rename_valid_o;
    logic                  rename_stall_o;
    rename_pkg::phys_reg_t prs1_o;
    rename_pkg::phys_reg_t prs2_o;
    rename_pkg::phys_reg_t prd_o;
    rename_pkg::phys_reg_t old_prd_o;

    // Reference model state
    rename_pkg::phys_reg_t ref_map [`RN_NUM_ARCH_REGS];  // Expected alias table
    rename_pkg::phys_reg_t ref_free [$];                 // Expected free list, head first
    rename_pkg::phys_reg_t held [$];                     // Old mappings awaiting commit

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) tb_clock_gen_i (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    rename_top rename_top_i (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .rename_valid_i (rename_valid_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .rd_i           (rd_i),
        .rd_we_i        (rd_we_i),
        .commit_valid_i (commit_valid_i),
        .commit_prd_i   (commit_prd_i),
        .rename_valid_o (rename_valid_o),
        .rename_stall_o (rename_stall_o),
        .prs1_o         (prs1_o),
        .prs2_o         (prs2_o),
        .prd_o          (prd_o),
        .old_prd_o      (old_prd_o)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s is %0d, expected %0d",
                     $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Identity map and p32 to p63 in the free list, as after reset
    task automatic model_reset();
        for (int i = 0; i < `RN_NUM_ARCH_REGS; i++) begin
            ref_map[i] = rename_pkg::phys_reg_t'(i);
        end
        ref_free.delete();
        for (int i = `RN_NUM_ARCH_REGS; i < `RN_NUM_PHYS_REGS; i++) begin
            ref_free.push_back(rename_pkg::phys_reg_t'(i));
        end
        held.delete();
    endtask

    // Picks one old mapping at random and removes it from the held set
    task automatic take_held(output rename_pkg::phys_reg_t preg);
        int idx;
        idx  = $urandom % held.size();
        preg = held[idx];
        held.delete(idx);
    endtask

    // One cycle: drive a request and commit, update the model, check the result
    // Called at drive time and returns at the next drive time
    task automatic rename_step(input logic valid, input rename_pkg::arch_reg_t rs1,
                               input rename_pkg::arch_reg_t rs2,
                               input rename_pkg::arch_reg_t rd, input logic we,
                               input logic cvalid, input rename_pkg::phys_reg_t cprd);
        rename_pkg::phys_reg_t exp_prs1;
        rename_pkg::phys_reg_t exp_prs2;
        rename_pkg::phys_reg_t exp_prd;
        rename_pkg::phys_reg_t exp_old;
        logic                  alloc;
        logic                  exp_stall;
        logic                  exp_valid;
        rename_valid_i = valid;
        rs1_i          = rs1;
        rs2_i          = rs2;
        rd_i           = rd;
        rd_we_i        = we;
        commit_valid_i = cvalid;
        commit_prd_i   = cprd;
        exp_prs1  = ref_map[rs1];                       // Sources see the map before update
        exp_prs2  = ref_map[rs2];
        exp_old   = ref_map[rd];
        exp_prd   = exp_old;                            // Kept when nothing is allocated
        alloc     = valid && we && (rd != '0);
        exp_stall = alloc && (ref_free.size() == 0);    // Commit this cycle comes too late
        exp_valid = valid && !exp_stall;
        if (alloc && !exp_stall) begin
            exp_prd     = ref_free.pop_front();
            ref_map[rd] = exp_prd;
            held.push_back(exp_old);                    // Freed later by a commit
        end
        if (cvalid && (cprd != '0)) begin
            ref_free.push_back(cprd);                   // p0 never returns to the list
        end
        @(posedge clk);
        #DRIVE_DELAY;
        check_value("rename_valid_o", rename_valid_o, exp_valid);
        check_value("rename_stall_o", rename_stall_o, exp_stall);
        if (exp_valid) begin
            check_value("prs1_o", prs1_o, exp_prs1);
            check_value("prs2_o", prs2_o, exp_prs2);
            check_value("prd_o", prd_o, exp_prd);
            check_value("old_prd_o", old_prd_o, exp_old);
        end
        rename_valid_i = 1'b0;                          // Strobes last one cycle
        commit_valid_i = 1'b0;
    endtask

    task automatic idle_step();
        rename_step(1'b0, '0, '0, '0, 1'b0, 1'b0, '0);
    endtask

    // Non writing requests read back the architectural indexes
    task automatic test_reset_identity();
        rename_pkg::arch_reg_t a;
        rename_pkg::arch_reg_t b;
        rename_pkg::arch_reg_t d;
        for (int k = 0; k < 3; k++) begin
            a = rename_pkg::arch_reg_t'(5 * k + 1);
            b = rename_pkg::arch_reg_t'(31 - 3 * k);
            d = rename_pkg::arch_reg_t'(9 + 6 * k);
            rename_step(1'b1, a, b, d, 1'b0, 1'b0, '0);
            check_value("prs1_o", prs1_o, a);          // Identity after reset
            check_value("prs2_o", prs2_o, b);
            check_value("prd_o", prd_o, d);
            check_value("old_prd_o", old_prd_o, d);
        end
        idle_step();
    endtask

    // Back to back writing renames, each reading the rd of the one before
    task automatic test_alloc_order();
        rename_pkg::phys_reg_t expect_new;
        rename_pkg::phys_reg_t last_new;
        rename_pkg::arch_reg_t prev_rd;
        rename_pkg::arch_reg_t d;
        prev_rd  = '0;
        last_new = '0;                                  // x0 reads p0
        for (int k = 0; k < ALLOC_RUN; k++) begin
            expect_new = rename_pkg::phys_reg_t'(`RN_NUM_ARCH_REGS + k);
            d          = rename_pkg::arch_reg_t'(k + 1);
            rename_step(1'b1, prev_rd, 5'd20, d, 1'b1, 1'b0, '0);
            check_value("prd_o", prd_o, expect_new);    // p32 upwards in order
            check_value("old_prd_o", old_prd_o, d);     // Still the reset mapping
            check_value("prs1_o", prs1_o, last_new);    // Sees the write of the last request
            last_new = expect_new;
            prev_rd  = d;
        end
        idle_step();
    endtask

    // Writes to x0 stay on p0 and leave the allocation sequence alone
    task automatic test_zero_register();
        rename_step(1'b1, 5'd3, 5'd4, 5'd0, 1'b1, 1'b0, '0);
        check_value("prd_o", prd_o, 0);
        check_value("old_prd_o", old_prd_o, 0);
        rename_step(1'b1, 5'd0, 5'd0, 5'd6, 1'b1, 1'b0, '0);
        check_value("prd_o", prd_o, `RN_NUM_ARCH_REGS + ALLOC_RUN);
        idle_step();
    endtask

    // Drain the free list, see the stall, then recycle one register
    task automatic test_exhaustion();
        rename_pkg::arch_reg_t d;
        rename_pkg::phys_reg_t freed;
        for (int k = ALLOC_RUN + 1; k < `RN_FREE_DEPTH; k++) begin
            d = rename_pkg::arch_reg_t'(1 + ($urandom % 31));
            rename_step(1'b1, d, 5'd0, d, 1'b1, 1'b0, '0);
        end
        rename_step(1'b1, 5'd1, 5'd2, 5'd7, 1'b1, 1'b0, '0);
        check_value("rename_stall_o", rename_stall_o, 1);   // 33rd allocation is dropped
        check_value("rename_valid_o", rename_valid_o, 0);
        take_held(freed);
        rename_step(1'b0, '0, '0, '0, 1'b0, 1'b1, freed);
        rename_step(1'b1, 5'd0, 5'd0, 5'd9, 1'b1, 1'b0, '0);
        check_value("prd_o", prd_o, freed);             // Only register on the list
        idle_step();
    endtask

    // Random requests mixed with commits of held old mappings
    task automatic test_random_mix();
        logic                  v;
        logic                  we;
        logic                  cv;
        rename_pkg::arch_reg_t a;
        rename_pkg::arch_reg_t b;
        rename_pkg::arch_reg_t d;
        rename_pkg::phys_reg_t cp;
        for (int k = 0; k < RANDOM_CYCLES; k++) begin
            v  = ($urandom % 4) != 0;
            we = ($urandom % 4) != 0;
            a  = rename_pkg::arch_reg_t'($urandom % `RN_NUM_ARCH_REGS);
            b  = rename_pkg::arch_reg_t'($urandom % `RN_NUM_ARCH_REGS);
            d  = rename_pkg::arch_reg_t'($urandom % `RN_NUM_ARCH_REGS);
            cv = 1'b0;
            cp = '0;
            if ((held.size() > 0) && (($urandom % 3) != 0)) begin
                cv = 1'b1;
                take_held(cp);
            end
            rename_step(v, a, b, d, we, cv, cp);
        end
        idle_step();
    endtask

    initial begin
        rename_valid_i = 1'b0;
        rs1_i          = '0;
        rs2_i          = '0;
        rd_i           = '0;
        rd_we_i        = 1'b0;
        commit_valid_i = 1'b0;
        commit_prd_i   = '0;
        void'($urandom(SEED));                          // One seed for the whole run
        model_reset();
        @(posedge rstn);
        @(posedge clk);
        #DRIVE_DELAY;
        test_reset_identity();
        test_alloc_order();
        test_zero_register();
        test_exhaustion();
        test_random_mix();
        $display("Simulation finished: PASS");
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog: the run timed out before all tests completed");
        $display("Simulation finished: FAIL");
        $fatal(1, "Timeout");
    end

endmodule

/* verilog.f */
+incdir+.
rename_pkg.sv
rat_if.sv
register_alias_table.sv
free_list.sv
rename_control.sv
rename_top.sv
tb_clock_gen.sv
tb_rename_top.sv
